// File: project.f
verilog/loader_pkg.sv
verilog/mem_pkg.sv
verilog/sdram_wr_if.sv
verilog/download_decoder.sv
verilog/word_packer.sv
verilog/sdram_write_arbiter.sv
verilog/memcard_control.sv
verilog/media_loader_top.sv
test/media_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the media_loader testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	--top-module media_loader_tb -f project.f -o media_loader_sim \
	&& ./obj_dir/media_loader_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

// File: test/media_loader_tb.sv
// Testbench for media_loader_top
//   Clock, reset and an SDRAM model with random ack delay
//   Directed tests for downloads, core writes, CD state and memory cards
`timescale 1ns/1ps

module media_loader_tb;
	import loader_pkg::*;
	import mem_pkg::*;

	localparam int unsigned BIOS_BASE = 2097152;
	localparam int unsigned EXE_BASE  = 4194304;
	localparam int          TIMEOUT   = 200;

	logic        clk_1x;
	logic        rst_n;
	logic        ioctl_download;
	dl_index_t   ioctl_index;
	host_addr_t  ioctl_addr;
	host_word_t  ioctl_dout;
	logic        ioctl_wr;
	logic        ioctl_wait;
	logic [3:0]  img_mounted;
	img_size_t   img_size;
	logic        bk_load;
	logic        bk_save;
	logic        bk_autosave;
	logic        osd_status;
	logic        core_reset;
	logic        load_exe;
	logic        cart_loaded;
	logic        has_cd;
	logic        cd_hps_on;
	cd_size_t    cd_size;
	crypt_key_t  libcrypt_key;
	logic [1:0]  memcard_available;
	logic [1:0]  memcard_load;
	logic        memcard_save;
	sdram_addr_t core_addr;
	sdram_data_t core_din;
	sdram_be_t   core_be;
	logic        core_req;
	logic        core_ack;
	sdram_addr_t sdram_addr;
	sdram_data_t sdram_din;
	sdram_be_t   sdram_be;
	logic        sdram_req;
	logic        sdram_ack;

	int errors = 0;
	int checks = 0;
	int timeouts = 0;
	// Pulse counts updated by the monitor only
	int load0_pulses = 0;
	int load1_pulses = 0;
	int save_pulses = 0;
	int core_acks = 0;

	// Memory model state and the writes it accepted
	logic        mem_busy;
	int unsigned mem_wait;
	sdram_addr_t wr_addr_q[$];
	sdram_data_t wr_data_q[$];
	sdram_be_t   wr_be_q[$];

	media_loader_top #(.BIOS_BASE(BIOS_BASE), .EXE_BASE(EXE_BASE), .NUM_CARDS(2)) dut_i (.*);

	initial begin
		clk_1x = 1'b0;
		forever #10 clk_1x = ~clk_1x;
	end

	// ========================================
	// SDRAM model with ack 1 to 6 cycles after req
	// ========================================
	initial begin
		sdram_ack = 1'b0;
		mem_busy  = 1'b0;
		mem_wait  = 0;
		forever begin
			@(posedge clk_1x);
			if (!rst_n) begin
				sdram_ack <= 1'b0;
				mem_busy  <= 1'b0;
			end else if (sdram_ack) begin
				sdram_ack <= 1'b0;
			end else if (sdram_req) begin
				if (!mem_busy) begin
					mem_busy <= 1'b1;
					mem_wait <= $urandom % 6;
				end else if (mem_wait == 0) begin
					sdram_ack <= 1'b1;
					mem_busy  <= 1'b0;
					wr_addr_q.push_back(sdram_addr);
					wr_data_q.push_back(sdram_din);
					wr_be_q.push_back(sdram_be);
				end else begin
					mem_wait <= mem_wait - 1;
				end
			end
		end
	end

	// Pulse counting between edges
	always @(negedge clk_1x) begin
		if (memcard_load[0]) load0_pulses++;
		if (memcard_load[1]) load1_pulses++;
		if (memcard_save) save_pulses++;
		if (core_ack) core_acks++;
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_done(input logic done, input string what);
		checks++;
		assert (done) else begin
			errors++;
			timeouts++;
			$display("Timeout while waiting for %s", what);
		end
	endtask

	task automatic check_write(input int idx, input sdram_addr_t addr, input sdram_data_t data,
			input sdram_be_t be);
		check_value("write count", 64'(wr_addr_q.size()), 64'(idx + 1));
		if (wr_addr_q.size() > idx) begin
			check_value("sdram_addr", 64'(wr_addr_q[idx]), 64'(addr));
			check_value("sdram_din", 64'(wr_data_q[idx]), 64'(data));
			check_value("sdram_be", 64'(wr_be_q[idx]), 64'(be));
		end
	endtask

	// ========================================
	// Host and core drivers
	// ========================================
	task automatic start_download(input dl_index_t idx);
		@(posedge clk_1x);
		ioctl_index    <= idx;
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_1x);
	endtask

	// Upper halfword waits for ioctl_wait to drop
	task automatic host_write(input host_addr_t addr, input host_word_t data);
		int n;
		@(posedge clk_1x);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
		if (addr[1]) begin
			@(negedge clk_1x);
			check_bit("ioctl_wait", ioctl_wait, 1'b1);
			n = 0;
			while (ioctl_wait && n < TIMEOUT) begin
				@(negedge clk_1x);
				n++;
			end
			check_done(!ioctl_wait, "ioctl_wait to clear");
		end
	endtask

	task automatic load_words(input host_addr_t start, input int words, input int unsigned base);
		host_addr_t  a;
		host_word_t  lo;
		host_word_t  hi;
		sdram_addr_t exp_addr;
		int          first;
		for (int i = 0; i < words; i++) begin
			a        = start + host_addr_t'(4 * i);
			lo       = host_word_t'($urandom);
			hi       = host_word_t'($urandom);
			exp_addr = sdram_addr_t'(base) + sdram_addr_t'(a);
			first    = wr_addr_q.size();
			host_write(a, lo);
			host_write(a + 27'd2, hi);
			check_write(first, exp_addr, {hi, lo}, 4'hf);
			check_bit("core_reset", core_reset, 1'b1);
		end
	endtask

	task automatic wait_core_ack();
		int n;
		n = 0;
		@(negedge clk_1x);
		while (!core_ack && n < TIMEOUT) begin
			@(negedge clk_1x);
			n++;
		end
		check_done(core_ack, "core_ack");
		@(posedge clk_1x);
		core_req <= 1'b0;
	endtask

	task automatic mount_image(input logic [3:0] bits, input img_size_t size);
		@(posedge clk_1x);
		img_mounted <= bits;
		img_size    <= size;
		@(posedge clk_1x);
		img_mounted <= 4'b0000;
		repeat (3) @(posedge clk_1x);
	endtask

	// ========================================
	// Directed tests
	// ========================================
	task automatic test_bios_download();
		start_download(IDX_BIOS);
		load_words(27'h000100, 4, BIOS_BASE);
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_1x);
	endtask

	task automatic test_cart_download();
		start_download(IDX_CART);
		load_words(27'h000040, 3, EXE_BASE);
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		// One pulse two cycles after the download ends
		for (int i = 0; i < 8; i++) begin
			@(negedge clk_1x);
			check_bit("load_exe", load_exe, i == 2);
		end
		check_bit("cart_loaded", cart_loaded, 1'b1);
	endtask

	task automatic test_core_writes();
		sdram_addr_t addr;
		sdram_data_t data;
		sdram_be_t   be;
		int          acks;
		int          first;
		for (int i = 0; i < 3; i++) begin
			@(posedge clk_1x);
			acks  = core_acks;
			first = wr_addr_q.size();
			addr  = 27'h0300000 + sdram_addr_t'(4 * i);
			data  = $urandom;
			be    = sdram_be_t'(i + 1);
			core_addr <= addr;
			core_din  <= data;
			core_be   <= be;
			core_req  <= 1'b1;
			wait_core_ack();
			repeat (2) @(posedge clk_1x);
			check_value("core_ack count", 64'(core_acks - acks), 64'd1);
			check_write(first, addr, data, be);
		end

		// Core request held off for the whole download
		start_download(IDX_BIOS);
		acks = core_acks;
		core_addr <= 27'h0350000;
		core_din  <= 32'hcafe_f00d;
		core_be   <= 4'hf;
		core_req  <= 1'b1;
		load_words(27'h000200, 2, BIOS_BASE);
		@(posedge clk_1x);
		check_value("core_ack count", 64'(core_acks - acks), 64'd0);
		first = wr_addr_q.size();
		ioctl_download <= 1'b0;
		wait_core_ack();
		repeat (2) @(posedge clk_1x);
		check_value("core_ack count", 64'(core_acks - acks), 64'd1);
		check_write(first, 27'h0350000, 32'hcafe_f00d, 4'hf);
	endtask

	task automatic test_cd_tracking();
		mount_image(4'b0010, 64'h0000_0001_2345_6789);
		@(negedge clk_1x);
		check_value("cd_size", 64'(cd_size), 64'h2345_6789);
		check_bit("cd_hps_on", cd_hps_on, 1'b1);
		check_bit("has_cd", has_cd, 1'b1);

		mount_image(4'b0010, 64'd0);
		@(negedge clk_1x);
		check_bit("has_cd", has_cd, 1'b0);

		// Index 0x42 shares its low 6 bits with the CD code
		start_download(8'h42);
		ioctl_addr <= 27'h0abcde4;
		@(negedge clk_1x);
		check_bit("core_reset", core_reset, 1'b1);
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		repeat (4) @(negedge clk_1x);
		check_value("cd_size", 64'(cd_size), 64'h0abcde4);
		check_bit("has_cd", has_cd, 1'b1);
		check_bit("cd_hps_on", cd_hps_on, 1'b0);

		start_download(IDX_SBI);
		ioctl_dout <= 16'hc3a5;
		ioctl_wr   <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		@(negedge clk_1x);
		check_value("libcrypt_key", 64'(libcrypt_key), 64'hc3a5);
	endtask

	task automatic test_memcards();
		int l0;
		int l1;
		int sv;
		l0 = load0_pulses;
		l1 = load1_pulses;
		mount_image(4'b1000, 64'd131072);
		check_value("memcard_load[1] pulses", 64'(load1_pulses - l1), 64'd1);
		check_value("memcard_load[0] pulses", 64'(load0_pulses - l0), 64'd0);
		@(negedge clk_1x);
		check_value("memcard_available", 64'(memcard_available), 64'h2);

		l1 = load1_pulses;
		mount_image(4'b1000, 64'd0);
		check_value("memcard_load[1] pulses", 64'(load1_pulses - l1), 64'd0);
		@(negedge clk_1x);
		check_value("memcard_available", 64'(memcard_available), 64'h0);

		@(posedge clk_1x);
		l0 = load0_pulses;
		l1 = load1_pulses;
		bk_load <= 1'b1;
		repeat (4) @(posedge clk_1x);
		bk_load <= 1'b0;
		check_value("memcard_load[0] pulses", 64'(load0_pulses - l0), 64'd1);
		check_value("memcard_load[1] pulses", 64'(load1_pulses - l1), 64'd1);

		sv = save_pulses;
		bk_save <= 1'b1;
		repeat (4) @(posedge clk_1x);
		bk_save <= 1'b0;
		check_value("memcard_save pulses", 64'(save_pulses - sv), 64'd1);

		// Autosave on OSD change
		bk_autosave <= 1'b1;
		repeat (2) @(posedge clk_1x);
		sv = save_pulses;
		osd_status <= 1'b1;
		repeat (4) @(posedge clk_1x);
		check_value("memcard_save pulses", 64'(save_pulses - sv), 64'd1);
		osd_status <= 1'b0;
		repeat (2) @(posedge clk_1x);
		bk_autosave <= 1'b0;
		repeat (2) @(posedge clk_1x);
		sv = save_pulses;
		osd_status <= 1'b1;
		repeat (4) @(posedge clk_1x);
		osd_status <= 1'b0;
		check_value("memcard_save pulses", 64'(save_pulses - sv), 64'd0);
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		void'($urandom(32'h2970c55a));
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		img_mounted    = '0;
		img_size       = '0;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		bk_autosave    = 1'b0;
		osd_status     = 1'b0;
		core_addr      = '0;
		core_din       = '0;
		core_be        = '0;
		core_req       = 1'b0;
		repeat (3) @(posedge clk_1x);
		rst_n <= 1'b1;
		@(negedge clk_1x);
		check_bit("ioctl_wait", ioctl_wait, 1'b0);
		check_bit("sdram_req", sdram_req, 1'b0);
		check_bit("core_ack", core_ack, 1'b0);
		check_bit("load_exe", load_exe, 1'b0);
		check_value("memcard_load", 64'(memcard_load), 64'h0);
		check_bit("memcard_save", memcard_save, 1'b0);
		check_bit("has_cd", has_cd, 1'b0);
		check_bit("cart_loaded", cart_loaded, 1'b0);

		test_bios_download();
		check_bit("cart_loaded", cart_loaded, 1'b0);
		test_cart_download();
		test_core_writes();
		test_cd_tracking();
		test_memcards();

		repeat (4) @(posedge clk_1x);
		$display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/media_loader_top.sv
// Media loader top level
//   Download decoder, word packer, write arbiter, memory cards
//   Loader and core write channels as two interface instances
`timescale 1ns/1ps

module media_loader_top #(
	parameter int unsigned BIOS_BASE = 2097152,
	parameter int unsigned EXE_BASE  = 4194304,
	parameter int          NUM_CARDS = 2
) (
	input  logic                    clk_1x,
	input  logic                    rst_n,
	// Host download
	input  logic                    ioctl_download,
	input  loader_pkg::dl_index_t   ioctl_index,
	input  loader_pkg::host_addr_t  ioctl_addr,
	input  loader_pkg::host_word_t  ioctl_dout,
	input  logic                    ioctl_wr,
	output logic                    ioctl_wait,
	// Image mounts with bit 1 as the CD and the cards above it
	input  logic [NUM_CARDS+1:0]    img_mounted,
	input  loader_pkg::img_size_t   img_size,
	input  logic                    bk_load,
	input  logic                    bk_save,
	input  logic                    bk_autosave,
	input  logic                    osd_status,
	// Core control
	output logic                    core_reset,
	output logic                    load_exe,
	output logic                    cart_loaded,
	output logic                    has_cd,
	output logic                    cd_hps_on,
	output loader_pkg::cd_size_t    cd_size,
	output loader_pkg::crypt_key_t  libcrypt_key,
	output logic [NUM_CARDS-1:0]    memcard_available,
	output logic [NUM_CARDS-1:0]    memcard_load,
	output logic                    memcard_save,
	// Core write port
	input  mem_pkg::sdram_addr_t    core_addr,
	input  mem_pkg::sdram_data_t    core_din,
	input  mem_pkg::sdram_be_t      core_be,
	input  logic                    core_req,
	output logic                    core_ack,
	// SDRAM write channel
	output mem_pkg::sdram_addr_t    sdram_addr,
	output mem_pkg::sdram_data_t    sdram_din,
	output mem_pkg::sdram_be_t      sdram_be,
	output logic                    sdram_req,
	input  logic                    sdram_ack
);

	logic dl_loading;
	logic dl_is_bios;

	sdram_wr_if pack_wr ();
	sdram_wr_if core_wr ();

	assign core_wr.addr = core_addr;
	assign core_wr.data = core_din;
	assign core_wr.be   = core_be;
	assign core_wr.req  = core_req;
	assign core_ack     = core_wr.ack;

	download_decoder decoder_i (
		.clk_1x, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr, .ioctl_dout,
		.ioctl_wr, .img_mounted_cd(img_mounted[1]), .img_size, .dl_loading, .dl_is_bios,
		.core_reset, .load_exe, .cart_loaded, .has_cd, .cd_hps_on, .cd_size, .libcrypt_key
	);

	word_packer #(.BIOS_BASE(BIOS_BASE), .EXE_BASE(EXE_BASE)) packer_i (
		.clk_1x, .rst_n, .dl_loading, .dl_is_bios, .ioctl_addr, .ioctl_dout,
		.ioctl_wr, .ioctl_wait, .pack_wr(pack_wr.requester)
	);

	sdram_write_arbiter arbiter_i (
		.clk_1x, .rst_n, .dl_loading, .sdram_ack, .sdram_addr, .sdram_din, .sdram_be,
		.sdram_req, .pack_wr(pack_wr.memory), .core_wr(core_wr.memory)
	);

	memcard_control #(.NUM_CARDS(NUM_CARDS)) memcard_i (
		.clk_1x, .rst_n, .img_mounted_card(img_mounted[NUM_CARDS+1:2]), .img_size,
		.bk_load, .bk_save, .bk_autosave, .osd_status, .memcard_available,
		.memcard_load, .memcard_save
	);

endmodule

// File: verilog/memcard_control.sv
// Memory card control
//   Mount state per card
//   Load pulses on mount and on reload request
//   Save pulses on save request and autosave
`timescale 1ns/1ps

module memcard_control #(
	parameter int NUM_CARDS = 2
) (
	input  logic                  clk_1x,
	input  logic                  rst_n,
	input  logic [NUM_CARDS-1:0]  img_mounted_card,
	input  loader_pkg::img_size_t img_size,
	input  logic                  bk_load,
	input  logic                  bk_save,
	input  logic                  bk_autosave,
	input  logic                  osd_status,
	output logic [NUM_CARDS-1:0]  memcard_available,
	output logic [NUM_CARDS-1:0]  memcard_load,
	output logic                  memcard_save
);

	logic bk_save_a;
	logic old_load;
	logic old_save;
	logic old_save_a;

	// Autosave fires when the OSD opens with autosave on
	assign bk_save_a = osd_status & bk_autosave;

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			memcard_available <= '0;
			memcard_load      <= '0;
			memcard_save      <= 1'b0;
			old_load          <= 1'b0;
			old_save          <= 1'b0;
			old_save_a        <= 1'b0;
		end else begin
			memcard_load <= '0;
			memcard_save <= 1'b0;
			old_load     <= bk_load;
			old_save     <= bk_save;
			old_save_a   <= bk_save_a;

			// Zero-size mount means eject
			for (int i = 0; i < NUM_CARDS; i++) begin
				if (img_mounted_card[i]) begin
					memcard_available[i] <= (img_size != '0);
					memcard_load[i]      <= (img_size != '0);
				end
			end

			// Reload all cards
			if (bk_load && !old_load)
				memcard_load <= '1;

			if ((bk_save && !old_save) || (bk_save_a && !old_save_a))
				memcard_save <= 1'b1;
		end
	end

endmodule

// File: verilog/sdram_write_arbiter.sv
// SDRAM write arbiter
//   Shares one write channel between loader and core
//   Owner is locked for a whole transfer
//   Ack goes back to the owner only
`timescale 1ns/1ps

module sdram_write_arbiter (
	input  logic                clk_1x,
	input  logic                rst_n,
	input  logic                dl_loading,
	input  logic                sdram_ack,
	output mem_pkg::sdram_addr_t sdram_addr,
	output mem_pkg::sdram_data_t sdram_din,
	output mem_pkg::sdram_be_t   sdram_be,
	output logic                sdram_req,
	sdram_wr_if.memory          pack_wr,
	sdram_wr_if.memory          core_wr
);

	logic busy;
	logic owner_loader;
	logic sel_loader;

	// Idle channel follows dl_loading and a running transfer keeps its owner
	assign sel_loader = busy ? owner_loader : dl_loading;

	// ========================================
	// Channel mux
	// ========================================
	always_comb begin
		if (sel_loader) begin
			sdram_addr = pack_wr.addr;
			sdram_din  = pack_wr.data;
			sdram_be   = pack_wr.be;
			sdram_req  = pack_wr.req;
		end else begin
			sdram_addr = core_wr.addr;
			sdram_din  = core_wr.data;
			sdram_be   = core_wr.be;
			sdram_req  = core_wr.req;
		end
	end

	assign pack_wr.ack = sdram_ack & sel_loader;
	assign core_wr.ack = sdram_ack & ~sel_loader;

	// ========================================
	// Owner lock
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			busy         <= 1'b0;
			owner_loader <= 1'b0;
		end else if (busy) begin
			if (sdram_ack)
				busy <= 1'b0;
		end else if (sdram_req && !sdram_ack) begin
			// Lock whoever was granted when the request went out
			busy         <= 1'b1;
			owner_loader <= sel_loader;
		end
	end

endmodule

// File: verilog/word_packer.sv
// Host word packer
//   Joins two host halfwords into one 32-bit SDRAM write
//   Offsets the address by the BIOS or exe base
//   Holds the host off with ioctl_wait until ack
`timescale 1ns/1ps

module word_packer #(
	parameter int unsigned BIOS_BASE = 2097152,
	parameter int unsigned EXE_BASE  = 4194304
) (
	input  logic                   clk_1x,
	input  logic                   rst_n,
	input  logic                   dl_loading,
	input  logic                   dl_is_bios,
	input  loader_pkg::host_addr_t ioctl_addr,
	input  loader_pkg::host_word_t ioctl_dout,
	input  logic                   ioctl_wr,
	output logic                   ioctl_wait,
	sdram_wr_if.requester          pack_wr
);
	import mem_pkg::*;

	localparam sdram_addr_t BIOS_OFS = sdram_addr_t'(BIOS_BASE);
	localparam sdram_addr_t EXE_OFS  = sdram_addr_t'(EXE_BASE);

	sdram_addr_t wr_addr;
	logic [15:0] data_lo;
	logic [15:0] data_hi;
	logic        wr_req;

	// ========================================
	// Halfword assembly
	// ========================================
	// Payload loaded by the host strobe only
	always_ff @(posedge clk_1x) begin
		if (dl_loading && ioctl_wr) begin
			if (!ioctl_addr[1]) begin
				data_lo <= ioctl_dout;
				wr_addr <= sdram_addr_t'(ioctl_addr) + (dl_is_bios ? BIOS_OFS : EXE_OFS);
			end else begin
				data_hi <= ioctl_dout;
			end
		end
	end

	// ========================================
	// Request and host wait
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			wr_req     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			// Request stays up until its ack, whatever the host does
			if (pack_wr.ack)
				wr_req <= 1'b0;

			if (dl_loading) begin
				if (pack_wr.ack)
					ioctl_wait <= 1'b0;
				// Upper half completes the word
				if (ioctl_wr && ioctl_addr[1]) begin
					wr_req     <= 1'b1;
					ioctl_wait <= 1'b1;
				end
			end else begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	assign pack_wr.addr = wr_addr;
	assign pack_wr.data = {data_hi, data_lo};
	assign pack_wr.be   = BE_ALL;
	assign pack_wr.req  = wr_req;

endmodule

// File: verilog/download_decoder.sv
// Download decoder
//   Download kind flags and core reset
//   Exe start pulse at the end of a cart download
//   CD image size and presence, protection key capture
`timescale 1ns/1ps

module download_decoder (
	input  logic                    clk_1x,
	input  logic                    rst_n,
	input  logic                    ioctl_download,
	input  loader_pkg::dl_index_t   ioctl_index,
	input  loader_pkg::host_addr_t  ioctl_addr,
	input  loader_pkg::host_word_t  ioctl_dout,
	input  logic                    ioctl_wr,
	input  logic                    img_mounted_cd,
	input  loader_pkg::img_size_t   img_size,
	output logic                    dl_loading,
	output logic                    dl_is_bios,
	output logic                    core_reset,
	output logic                    load_exe,
	output logic                    cart_loaded,
	output logic                    has_cd,
	output logic                    cd_hps_on,
	output loader_pkg::cd_size_t    cd_size,
	output loader_pkg::crypt_key_t  libcrypt_key
);
	import loader_pkg::*;

	logic bios_dl;
	logic cart_dl;
	logic cd_dl;
	logic sbi_dl;
	logic cart_dl_d;
	logic cd_dl_d;

	// ========================================
	// Download kind flags
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			bios_dl <= 1'b0;
			cart_dl <= 1'b0;
			cd_dl   <= 1'b0;
			sbi_dl  <= 1'b0;
		end else begin
			bios_dl <= ioctl_download && (ioctl_index == IDX_BIOS);
			cart_dl <= ioctl_download && (ioctl_index == IDX_CART);
			cd_dl   <= ioctl_download && (ioctl_index[5:0] == IDX_CD[5:0]);
			sbi_dl  <= ioctl_download && (ioctl_index == IDX_SBI);
		end
	end

	// Only BIOS and cart data go to SDRAM
	assign dl_loading = bios_dl | cart_dl;
	assign dl_is_bios = bios_dl;

	// Core held in reset for the whole of an image download
	assign core_reset = ~rst_n | bios_dl | cart_dl | cd_dl;

	// ========================================
	// Download end, CD and key tracking
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			cart_dl_d   <= 1'b0;
			cd_dl_d     <= 1'b0;
			load_exe    <= 1'b0;
			cart_loaded <= 1'b0;
			has_cd      <= 1'b0;
			cd_hps_on   <= 1'b0;
		end else begin
			cart_dl_d <= cart_dl;
			cd_dl_d   <= cd_dl;
			load_exe  <= cart_dl_d & ~cart_dl;

			if (cart_dl || cd_dl || img_mounted_cd)
				cart_loaded <= 1'b1;

			// Downloaded CD takes the last host address as its size
			if (cd_dl_d && !cd_dl) begin
				cd_size   <= cd_size_t'(ioctl_addr);
				cd_hps_on <= 1'b0;
				has_cd    <= 1'b1;
			end

			// Mounted CD is streamed from the host and a later mount wins
			if (img_mounted_cd) begin
				if (img_size != '0) begin
					cd_size   <= img_size[29:0];
					cd_hps_on <= 1'b1;
					has_cd    <= 1'b1;
				end else begin
					has_cd <= 1'b0;
				end
			end

			if (sbi_dl && ioctl_wr)
				libcrypt_key <= ioctl_dout;
		end
	end

endmodule

// File: verilog/sdram_wr_if.sv
// SDRAM write channel interface
//   Requester side drives address, data, enables and req
//   Memory side returns a one-cycle ack
`timescale 1ns/1ps

interface sdram_wr_if;
	import mem_pkg::*;

	sdram_addr_t addr;
	sdram_data_t data;
	sdram_be_t   be;
	// Level request held with the payload until ack
	logic        req;
	logic        ack;

	modport requester (
		output addr, data, be, req,
		input  ack
	);

	modport memory (
		input  addr, data, be, req,
		output ack
	);

endinterface

// File: verilog/mem_pkg.sv
// SDRAM write channel definitions
//   Address, data and byte-enable types
//   Full-word byte-enable constant
package mem_pkg;

	// ========================================
	// SDRAM write channel
	// ========================================

	// Byte address into the SDRAM
	typedef logic [26:0] sdram_addr_t;

	// One 32-bit write word
	typedef logic [31:0] sdram_data_t;

	// One enable per byte lane
	typedef logic [3:0]  sdram_be_t;

	// All lanes written
	localparam sdram_be_t BE_ALL = 4'b1111;

endpackage

// File: verilog/loader_pkg.sv
// Host download side definitions
//   Host address, data word and index types
//   Download index codes for BIOS, cart, CD and SBI images
//   CD size, mounted image size and protection key types
package loader_pkg;

	// ========================================
	// Host download bus
	// ========================================

	// Byte address of the current host word
	typedef logic [26:0] host_addr_t;
	typedef logic [15:0] host_word_t;
	typedef logic [7:0]  dl_index_t;

	// Index codes sent by the host with a download
	localparam dl_index_t IDX_BIOS = 8'd0;
	localparam dl_index_t IDX_CART = 8'd1;
	// Only the low 6 bits are compared for CD images
	localparam dl_index_t IDX_CD   = 8'd2;
	localparam dl_index_t IDX_SBI  = 8'd250;

	// ========================================
	// Image and key state
	// ========================================

	typedef logic [29:0] cd_size_t;
	typedef logic [63:0] img_size_t;
	typedef logic [15:0] crypt_key_t;

endpackage
